/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module cache_system_tb -f flist.f -o cache_sim
	./obj_dir/cache_sim

clean:
	rm -rf obj_dir

/* flist.f */
src/cache_pkg.sv
src/cache_store.sv
src/cache_controller.sv
src/data_memory.sv
src/cache_system.sv
verification/cache_assertions.sv
verification/cache_system_tb.sv

/* src/cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_controller
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W
) (
  input  wire logic              clk,
  input  wire logic              reset,
  // processor side
  input  wire logic              req_valid,
  input  wire logic [ADDR_W-1:0] addr,
  input  wire logic              read,
  input  wire logic              write,
  input  wire logic [WORD_W-1:0] wdata,
  output logic                   ready,
  output logic                   resp_valid,
  output logic                   hit,
  // store side
  output logic [ADDR_W-1:0]      lookup_addr,
  output logic                   write_word,
  output logic [WORD_W-1:0]      store_wdata,
  output logic                   fill_line,
  output logic                   set_tag_valid,
  output logic                   set_dirty,
  output logic                   clear_dirty,
  input  wire logic              lookup_hit,
  input  wire logic              victim_dirty,
  input  wire logic [TAG_W-1:0]  victim_tag,
  // memory side
  output logic                   mem_req,
  output logic                   mem_write,
  output logic [ADDR_W-1:0]      mem_addr,
  input  wire logic              mem_ready,
  input  wire logic              mem_resp_valid
);

  typedef enum logic {
    op_read,
    op_write
  } req_op_t;

  cache_state_t state;
  cache_state_t next_state;

  logic [ADDR_W-1:0] req_addr;
  logic [WORD_W-1:0] req_wdata;
  req_op_t           req_op;
  logic              miss_seen;
  logic              accept;
  logic [ADDR_W-1:0] fetch_addr;
  logic [ADDR_W-1:0] victim_addr;

  assign ready  = (state == state_idle);
  assign accept = req_valid && ready;

  // held request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= addr;
      req_wdata <= wdata;
      req_op    <= (write && !read) ? op_write : op_read;
    end
  end

  assign lookup_addr = req_addr;
  assign store_wdata = req_wdata;

  // line-aligned addresses for fetch and write-back
  assign fetch_addr  = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign victim_addr = {victim_tag, req_addr[OFFSET_W +: IDX_W], {OFFSET_W{1'b0}}};

  // completion is always a hit in the compare state
  assign resp_valid = (state == state_compare) && lookup_hit;
  assign hit        = resp_valid && !miss_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= state_idle;
      miss_seen <= 1'b0;
    end else begin
      state <= next_state;
      if (accept) begin
        miss_seen <= 1'b0;
      end else if (state == state_compare && !lookup_hit) begin
        miss_seen <= 1'b1;
      end
    end
  end

  always_comb begin
    next_state    = state;
    write_word    = 1'b0;
    set_dirty     = 1'b0;
    clear_dirty   = 1'b0;
    set_tag_valid = 1'b0;
    fill_line     = 1'b0;
    mem_req       = 1'b0;
    mem_write     = 1'b0;
    mem_addr      = fetch_addr;
    case (state)
      state_idle: begin
        if (req_valid) begin
          next_state = state_compare;
        end
      end
      state_compare: begin
        if (lookup_hit) begin
          if (req_op == op_write) begin
            write_word = 1'b1;
            set_dirty  = 1'b1;
          end
          next_state = state_idle;
        end else if (mem_ready) begin
          // dirty victim goes out first
          mem_req = 1'b1;
          if (victim_dirty) begin
            mem_write  = 1'b1;
            mem_addr   = victim_addr;
            next_state = state_write_back;
          end else begin
            next_state = state_allocate;
          end
        end
      end
      state_write_back: begin
        if (mem_ready) begin
          mem_req    = 1'b1;
          next_state = state_allocate;
        end
      end
      state_allocate: begin
        // claim the set for the new tag
        set_tag_valid = 1'b1;
        clear_dirty   = 1'b1;
        if (mem_resp_valid) begin
          fill_line  = 1'b1;
          next_state = state_compare;
        end else begin
          next_state = state_fill_wait;
        end
      end
      state_fill_wait: begin
        if (mem_resp_valid) begin
          fill_line  = 1'b1;
          next_state = state_compare;
        end
      end
      default: next_state = state_idle;
    endcase
  end

endmodule

`default_nettype wire

/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // processor address and data widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // line geometry
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_W = 4;
  localparam int LINE_W = LINE_WORDS * WORD_W;

  // controller states
  typedef enum logic [2:0] {
    state_idle,
    state_compare,
    state_write_back,
    state_allocate,
    state_fill_wait
  } cache_state_t;

endpackage

`default_nettype wire

/* src/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic [ADDR_W-1:0] lookup_addr,
  input  wire logic              write_word,
  input  wire logic [WORD_W-1:0] store_wdata,
  input  wire logic              fill_line,
  input  wire logic [LINE_W-1:0] fill_data,
  input  wire logic              set_tag_valid,
  input  wire logic              set_dirty,
  input  wire logic              clear_dirty,
  output logic                   lookup_hit,
  output logic                   victim_dirty,
  output logic [TAG_W-1:0]       victim_tag,
  output logic [LINE_W-1:0]      victim_line,
  output logic [WORD_W-1:0]      read_word
);

  localparam int WSEL_W = $clog2(LINE_WORDS);

  logic [TAG_W-1:0]  tag_array [NUM_SETS];
  logic [LINE_W-1:0] data_array [NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits;
  logic [NUM_SETS-1:0] dirty_bits;

  logic [TAG_W-1:0]  addr_tag;
  logic [IDX_W-1:0]  addr_idx;
  logic [WSEL_W-1:0] word_sel;
  logic [LINE_W-1:0] merged_line;

  // address split: tag | index | word | byte
  assign addr_tag = lookup_addr[ADDR_W-1 -: TAG_W];
  assign addr_idx = lookup_addr[OFFSET_W +: IDX_W];
  assign word_sel = lookup_addr[OFFSET_W-1 -: WSEL_W];

  // the only place tag equality is tested
  assign lookup_hit   = valid_bits[addr_idx] && (tag_array[addr_idx] == addr_tag);
  assign victim_dirty = valid_bits[addr_idx] && dirty_bits[addr_idx];
  assign victim_tag   = tag_array[addr_idx];
  assign victim_line  = data_array[addr_idx];

  // word k sits at bits [k*WORD_W +: WORD_W]
  assign read_word = data_array[addr_idx][word_sel*WORD_W +: WORD_W];

  always_comb begin
    merged_line = data_array[addr_idx];
    merged_line[word_sel*WORD_W +: WORD_W] = store_wdata;
  end

  // line data and tags
  always_ff @(posedge clk) begin
    if (fill_line) begin
      data_array[addr_idx] <= fill_data;
    end else if (write_word) begin
      data_array[addr_idx] <= merged_line;
    end
    if (set_tag_valid) begin
      tag_array[addr_idx] <= addr_tag;
    end
  end

  // status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (set_tag_valid) begin
        valid_bits[addr_idx] <= 1'b1;
      end
      // a fresh line from memory is always clean
      if (set_dirty) begin
        dirty_bits[addr_idx] <= 1'b1;
      end else if (clear_dirty || fill_line) begin
        dirty_bits[addr_idx] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/cache_system.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_system
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int MEM_LATENCY = 6,
  parameter int MEM_LINES = 256
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              req_valid,
  input  wire logic [ADDR_W-1:0] addr,
  input  wire logic              read,
  input  wire logic              write,
  input  wire logic [WORD_W-1:0] wdata,
  output logic                   ready,
  output logic                   resp_valid,
  output logic [WORD_W-1:0]      rdata,
  output logic                   hit
);

  localparam int TAG_W = ADDR_W - $clog2(NUM_SETS) - OFFSET_W;

  // controller to store
  logic [ADDR_W-1:0] lookup_addr;
  logic              write_word;
  logic [WORD_W-1:0] store_wdata;
  logic              fill_line;
  logic              set_tag_valid;
  logic              set_dirty;
  logic              clear_dirty;
  logic              lookup_hit;
  logic              victim_dirty;
  logic [TAG_W-1:0]  victim_tag;
  logic [LINE_W-1:0] victim_line;

  // controller and store to memory
  logic              mem_req;
  logic              mem_write;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_ready;
  logic              mem_resp_valid;
  logic [LINE_W-1:0] mem_rline;

  cache_controller #(
    .NUM_SETS (NUM_SETS)
  ) controller (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .addr           (addr),
    .read           (read),
    .write          (write),
    .wdata          (wdata),
    .ready          (ready),
    .resp_valid     (resp_valid),
    .hit            (hit),
    .lookup_addr    (lookup_addr),
    .write_word     (write_word),
    .store_wdata    (store_wdata),
    .fill_line      (fill_line),
    .set_tag_valid  (set_tag_valid),
    .set_dirty      (set_dirty),
    .clear_dirty    (clear_dirty),
    .lookup_hit     (lookup_hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .mem_req        (mem_req),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_ready      (mem_ready),
    .mem_resp_valid (mem_resp_valid)
  );

  // read data comes straight from the addressed word
  cache_store #(
    .NUM_SETS (NUM_SETS)
  ) store (
    .clk           (clk),
    .reset         (reset),
    .lookup_addr   (lookup_addr),
    .write_word    (write_word),
    .store_wdata   (store_wdata),
    .fill_line     (fill_line),
    .fill_data     (mem_rline),
    .set_tag_valid (set_tag_valid),
    .set_dirty     (set_dirty),
    .clear_dirty   (clear_dirty),
    .lookup_hit    (lookup_hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_line   (victim_line),
    .read_word     (rdata)
  );

  data_memory #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_LINES   (MEM_LINES)
  ) data_mem (
    .clk            (clk),
    .reset          (reset),
    .mem_req        (mem_req),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_wline      (victim_line),
    .mem_ready      (mem_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_rline      (mem_rline)
  );

endmodule

`default_nettype wire

/* src/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory
  import cache_pkg::*;
#(
  parameter int MEM_LATENCY = 6,
  parameter int MEM_LINES = 256
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              mem_req,
  input  wire logic              mem_write,
  input  wire logic [ADDR_W-1:0] mem_addr,
  input  wire logic [LINE_W-1:0] mem_wline,
  output logic                   mem_ready,
  output logic                   mem_resp_valid,
  output logic [LINE_W-1:0]      mem_rline
);

  localparam int LINE_IDX_W = $clog2(MEM_LINES);
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  logic [LINE_W-1:0] mem_array [MEM_LINES];

  logic                  busy;
  logic [CNT_W-1:0]      count;
  logic                  read_pending;
  logic [LINE_IDX_W-1:0] line_q;
  logic                  resp_q;
  logic [LINE_W-1:0]     rline_q;

  logic                  filling;
  logic [LINE_IDX_W-1:0] fill_idx;
  logic [LINE_W-1:0]     fill_pattern;

  logic                  accept;
  logic                  resp_next;
  logic [LINE_IDX_W-1:0] req_line;
  logic [LINE_IDX_W-1:0] rd_line;

  // addresses wrap modulo the depth
  assign req_line = mem_addr[OFFSET_W +: LINE_IDX_W];
  assign accept   = mem_req && mem_ready;

  assign mem_ready      = !busy && !filling;
  assign mem_resp_valid = resp_q;
  assign mem_rline      = rline_q;

  // response lands the cycle ready comes back
  assign resp_next = (accept && !mem_write && MEM_LATENCY == 1) ||
                     (busy && count == CNT_W'(1) && read_pending);
  assign rd_line   = accept ? req_line : line_q;

  // each word holds its own byte address
  always_comb begin
    for (int k = 0; k < LINE_WORDS; k++) begin
      fill_pattern[k*WORD_W +: WORD_W] =
        (WORD_W'(fill_idx) << OFFSET_W) + WORD_W'(k * (WORD_W / 8));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      count        <= '0;
      read_pending <= 1'b0;
      resp_q       <= 1'b0;
      filling      <= 1'b1;
      fill_idx     <= '0;
    end else begin
      resp_q <= resp_next;
      if (filling) begin
        fill_idx <= fill_idx + 1'b1;
        if (fill_idx == LINE_IDX_W'(MEM_LINES - 1)) begin
          filling <= 1'b0;
        end
      end
      if (accept) begin
        busy         <= (MEM_LATENCY > 1);
        count        <= CNT_W'(MEM_LATENCY - 1);
        read_pending <= !mem_write;
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // storage, write at acceptance, read at response
  always_ff @(posedge clk) begin
    if (filling) begin
      mem_array[fill_idx] <= fill_pattern;
    end else if (accept && mem_write) begin
      mem_array[req_line] <= mem_wline;
    end
    if (accept) begin
      line_q <= req_line;
    end
    if (resp_next) begin
      rline_q <= mem_array[rd_line];
    end
  end

endmodule

`default_nettype wire

/* verification/cache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_assertions (
  input wire logic clk,
  input wire logic reset,
  input wire logic ready,
  input wire logic resp_valid,
  input wire logic mem_req,
  input wire logic mem_ready
);

  // memory side handshake
  req_needs_ready: assert property (@(posedge clk) disable iff (reset) mem_req |-> mem_ready)
    else $error("memory request raised while memory not ready");

  resp_not_ready: assert property (@(posedge clk) disable iff (reset) !(resp_valid && ready))
    else $error("response and ready high together");

  resp_single_cycle: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid)
    else $error("response held longer than one cycle");

  ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> ready)
    else $error("not ready right after reset");

endmodule

bind cache_controller cache_assertions controller_checks (
  .clk        (clk),
  .reset      (reset),
  .ready      (ready),
  .resp_valid (resp_valid),
  .mem_req    (mem_req),
  .mem_ready  (mem_ready)
);

`default_nettype wire

/* verification/cache_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_system_tb
  import cache_pkg::*;
();

  localparam int NUM_SETS = 16;
  localparam int MEM_LATENCY = 6;
  localparam int MEM_LINES = 256;
  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;
  localparam int TABLE_LEN = 19;
  localparam int RANDOM_OPS = 40;
  localparam int MODEL_LINES = 64;
  localparam int MODEL_WORDS = MODEL_LINES * LINE_WORDS;
  localparam logic [31:0] LFSR_SEED = 32'd71037;
  localparam int TIMEOUT_CYCLES = (TABLE_LEN + RANDOM_OPS) * (4 * MEM_LATENCY + 8);

  typedef struct {
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic [WORD_W-1:0] exp_rdata;
    logic              exp_hit;
  } stim_entry_t;

  logic              clk;
  logic              reset;
  logic              req_valid;
  logic [ADDR_W-1:0] addr;
  logic              read;
  logic              write;
  logic [WORD_W-1:0] wdata;
  logic              ready;
  logic              resp_valid;
  logic [WORD_W-1:0] rdata;
  logic              hit;

  stim_entry_t         stim [TABLE_LEN];
  logic [WORD_W-1:0]   mirror [MODEL_WORDS];
  logic [TAG_W-1:0]    shadow_tag [NUM_SETS];
  logic [NUM_SETS-1:0] shadow_valid;
  logic [31:0]         lfsr_state;
  int                  cycle_count = 0;

  cache_system #(
    .NUM_SETS    (NUM_SETS),
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_LINES   (MEM_LINES)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .addr       (addr),
    .read       (read),
    .write      (write),
    .wdata      (wdata),
    .ready      (ready),
    .resp_valid (resp_valid),
    .rdata      (rdata),
    .hit        (hit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "simulation ran past its cycle limit");
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", what);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // processor view of memory, every word starts at its byte address
  task automatic init_model();
    for (int i = 0; i < MODEL_WORDS; i++) begin
      mirror[i] = WORD_W'(i * 4);
    end
    shadow_valid = '0;
  endtask

  task automatic model_access(input logic is_write, input logic [ADDR_W-1:0] a,
                              input logic [WORD_W-1:0] d,
                              output logic [WORD_W-1:0] exp_rdata, output logic exp_hit);
    int                widx;
    logic [IDX_W-1:0]  sidx;
    logic [TAG_W-1:0]  tag;
    widx = int'(a >> 2) % MODEL_WORDS;
    sidx = a[OFFSET_W +: IDX_W];
    tag  = a[ADDR_W-1 -: TAG_W];
    exp_hit = shadow_valid[sidx] && (shadow_tag[sidx] == tag);
    shadow_valid[sidx] = 1'b1;
    shadow_tag[sidx]   = tag;
    if (is_write) begin
      mirror[widx] = d;
    end
    exp_rdata = mirror[widx];
  endtask

  task automatic load_table();
    // cold read, then hits on the same line
    stim[0]  = '{1'b0, 32'h0000_0040, 32'h0, 32'h0000_0040, 1'b0};
    stim[1]  = '{1'b0, 32'h0000_0040, 32'h0, 32'h0000_0040, 1'b1};
    stim[2]  = '{1'b0, 32'h0000_0048, 32'h0, 32'h0000_0048, 1'b1};
    // write hit, neighbors untouched
    stim[3]  = '{1'b1, 32'h0000_0044, 32'ha5a5_0044, 32'h0, 1'b1};
    stim[4]  = '{1'b0, 32'h0000_0044, 32'h0, 32'ha5a5_0044, 1'b1};
    stim[5]  = '{1'b0, 32'h0000_0040, 32'h0, 32'h0000_0040, 1'b1};
    stim[6]  = '{1'b0, 32'h0000_004c, 32'h0, 32'h0000_004c, 1'b1};
    // write miss allocates
    stim[7]  = '{1'b1, 32'h0000_0088, 32'h1234_5678, 32'h0, 1'b0};
    stim[8]  = '{1'b0, 32'h0000_0088, 32'h0, 32'h1234_5678, 1'b1};
    stim[9]  = '{1'b0, 32'h0000_0080, 32'h0, 32'h0000_0080, 1'b1};
    stim[10] = '{1'b0, 32'h0000_0084, 32'h0, 32'h0000_0084, 1'b1};
    stim[11] = '{1'b0, 32'h0000_008c, 32'h0, 32'h0000_008c, 1'b1};
    // same index evicts the dirty line, then it comes back from memory
    stim[12] = '{1'b0, 32'h0000_0144, 32'h0, 32'h0000_0144, 1'b0};
    stim[13] = '{1'b0, 32'h0000_0044, 32'h0, 32'ha5a5_0044, 1'b0};
    stim[14] = '{1'b0, 32'h0000_0048, 32'h0, 32'h0000_0048, 1'b1};
    // write miss over a dirty victim
    stim[15] = '{1'b1, 32'h0000_0188, 32'hdead_beef, 32'h0, 1'b0};
    stim[16] = '{1'b0, 32'h0000_0088, 32'h0, 32'h1234_5678, 1'b0};
    stim[17] = '{1'b0, 32'h0000_0188, 32'h0, 32'hdead_beef, 1'b0};
    stim[18] = '{1'b0, 32'h0000_018c, 32'h0, 32'h0000_018c, 1'b1};
  endtask

  // one request from drive to response, latency counted from acceptance
  task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] a,
                            input logic [WORD_W-1:0] d,
                            output logic [WORD_W-1:0] got_rdata, output logic got_hit,
                            output int latency);
    logic resp_seen;
    @(posedge clk);
    req_valid <= 1'b1;
    read      <= !is_write;
    write     <= is_write;
    addr      <= a;
    wdata     <= d;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end
    // the coming edge accepts it
    @(posedge clk);
    req_valid <= 1'b0;
    read      <= 1'b0;
    write     <= 1'b0;
    latency   = 0;
    resp_seen = 1'b0;
    while (!resp_seen) begin
      @(negedge clk);
      latency++;
      check_value("ready while busy", 32'(ready), 32'd0);
      resp_seen = resp_valid;
    end
    got_rdata = rdata;
    got_hit   = hit;
    @(negedge clk);
    check_value("ready after response", 32'(ready), 32'd1);
  endtask

  initial begin
    logic [WORD_W-1:0] got_rdata;
    logic [WORD_W-1:0] exp_rdata;
    logic              got_hit;
    logic              exp_hit;
    int                latency;
    logic              rnd_write;
    logic [ADDR_W-1:0] rnd_addr;
    logic [WORD_W-1:0] rnd_data;

    reset      = 1'b1;
    req_valid  = 1'b0;
    addr       = '0;
    read       = 1'b0;
    write      = 1'b0;
    wdata      = '0;
    lfsr_state = LFSR_SEED;
    load_table();
    init_model();

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end

    for (int i = 0; i < TABLE_LEN; i++) begin
      model_access(stim[i].is_write, stim[i].addr, stim[i].data, exp_rdata, exp_hit);
      run_access(stim[i].is_write, stim[i].addr, stim[i].data, got_rdata, got_hit, latency);
      if (!stim[i].is_write) begin
        check_value("directed rdata", got_rdata, stim[i].exp_rdata);
      end
      check_value("directed hit", 32'(got_hit), 32'(stim[i].exp_hit));
      if (stim[i].exp_hit) begin
        check_value("hit latency", 32'(latency), 32'd1);
      end
    end

    // random mix over 64 lines, four tags per set
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd_addr  = take_bits(6) << OFFSET_W;
      rnd_addr  = rnd_addr | (take_bits(2) << 2);
      rnd_write = next_bit();
      rnd_data  = rnd_write ? take_bits(32) : '0;
      model_access(rnd_write, rnd_addr, rnd_data, exp_rdata, exp_hit);
      run_access(rnd_write, rnd_addr, rnd_data, got_rdata, got_hit, latency);
      if (!rnd_write) begin
        check_value("random rdata", got_rdata, exp_rdata);
      end
      check_value("random hit", 32'(got_hit), 32'(exp_hit));
      if (exp_hit) begin
        check_value("hit latency", 32'(latency), 32'd1);
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
